/* common/cpuDefsPkg.sv */
package cpuDefsPkg;

    // datapath
    localparam int dataWidth = 32;
    localparam int immWidth = 16;                   // i-type immediate field
    localparam int fieldWidth = 6;                  // opcode and funct fields

    // instruction field positions
    localparam int opcodeLsb = 26;
    localparam int functLsb = 0;
    localparam int immLsb = 0;

    // predictor sizing
    localparam int historyBits = 7;
    localparam int tableDepth = 1 << historyBits;   // one counter per history value
    localparam int counterBits = 2;

    typedef logic [dataWidth-1:0] dataWord;
    typedef logic [historyBits-1:0] historyType;
    typedef logic [counterBits-1:0] counterType;
    typedef logic [fieldWidth-1:0] opcodeType;
    typedef logic [fieldWidth-1:0] functType;

    // counter states, 2 and 3 predict taken
    localparam counterType counterInit = 2'd2;      // weakly taken
    localparam counterType counterMax = 2'd3;
    localparam counterType counterMin = 2'd0;
    localparam counterType takenThreshold = 2'd2;

    // opcode encodings
    localparam opcodeType opcodeRType = 6'd0;
    localparam opcodeType opcodeSlti = 6'd10;
    localparam opcodeType opcodeLw = 6'd35;
    localparam opcodeType opcodeSw = 6'd43;
    localparam opcodeType opcodeBeq = 6'd4;

    // function encodings, r-type only
    localparam functType functAdd = 6'd32;
    localparam functType functSub = 6'd34;
    localparam functType functSlt = 6'd42;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluSlt = 2'd2
    } aluOpType;

endpackage

/* execute/instructionExecute.sv */
module instructionExecute (
    input  logic               instrValid,
    input  cpuDefsPkg::dataWord instruction,
    input  cpuDefsPkg::dataWord operandA,
    input  cpuDefsPkg::dataWord operandB,
    input  cpuDefsPkg::dataWord pcPlus4,
    output logic               resultValidNext,
    output logic               overflowNext,
    output logic               branchValidNext,
    output logic               branchTakenNext,
    output cpuDefsPkg::dataWord aluResult,
    output cpuDefsPkg::dataWord branchTarget
);
    import cpuDefsPkg::*;

    opcodeType opcodeField;
    functType functField;
    logic [immWidth-1:0] immField;
    dataWord immExtended;
    dataWord secondOperand;
    dataWord sumResult;
    dataWord diffResult;
    aluOpType aluOp;
    logic useImmediate;
    logic isSupported;
    logic isBranch;
    logic lessThan;
    logic addOverflow;

    assign opcodeField = instruction[opcodeLsb +: fieldWidth];
    assign functField = instruction[functLsb +: fieldWidth];
    assign immField = instruction[immLsb +: immWidth];
    assign immExtended = {{(dataWidth-immWidth){immField[immWidth-1]}}, immField};

    // decode table
    always_comb begin
        aluOp = aluAdd;
        useImmediate = 1'b0;
        isSupported = 1'b0;
        isBranch = 1'b0;
        case (opcodeField)
            opcodeRType: begin
                case (functField)
                    functAdd: begin
                        aluOp = aluAdd;
                        isSupported = 1'b1;
                    end
                    functSub: begin
                        aluOp = aluSub;
                        isSupported = 1'b1;
                    end
                    functSlt: begin
                        aluOp = aluSlt;
                        isSupported = 1'b1;
                    end
                    default: isSupported = 1'b0;    // unknown funct
                endcase
            end
            opcodeSlti: begin
                aluOp = aluSlt;
                useImmediate = 1'b1;
                isSupported = 1'b1;
            end
            opcodeLw, opcodeSw: begin
                aluOp = aluAdd;                     // address add only
                useImmediate = 1'b1;
                isSupported = 1'b1;
            end
            opcodeBeq: begin
                isBranch = 1'b1;
                isSupported = 1'b1;
            end
            default: isSupported = 1'b0;
        endcase
    end

    assign secondOperand = useImmediate ? immExtended : operandB;

    assign sumResult = operandA + secondOperand;
    assign diffResult = operandA - secondOperand;
    assign lessThan = $signed(operandA) < $signed(secondOperand);

    // signed overflow: same input signs, result sign flips
    assign addOverflow = (operandA[dataWidth-1] == secondOperand[dataWidth-1]) &&
                         (sumResult[dataWidth-1] != operandA[dataWidth-1]);

    always_comb begin
        case (aluOp)
            aluSub:  aluResult = diffResult;
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, lessThan};
            default: aluResult = sumResult;
        endcase
    end

    assign resultValidNext = instrValid && isSupported && !isBranch;
    assign overflowNext = resultValidNext && (aluOp == aluAdd) && addOverflow;

    assign branchValidNext = instrValid && isBranch;
    assign branchTakenNext = (operandA == operandB);             // beq compares registers
    assign branchTarget = pcPlus4 + {immExtended[dataWidth-3:0], 2'b00}; // word offset

endmodule

/* predictor/globalHistoryPredictor.sv */
module globalHistoryPredictor (
    input  logic clockSignal,
    input  logic resetSignal,
    input  logic branchValidNext,
    input  logic branchTakenNext,
    output logic predictedTaken
);
    import cpuDefsPkg::*;

    historyType historyReg;
    counterType counterTable [tableDepth];
    counterType currentCounter;

    // table indexed straight by the global history
    assign currentCounter = counterTable[historyReg];
    assign predictedTaken = (currentCounter >= takenThreshold);

    always_ff @(posedge clockSignal) begin
        if (resetSignal) begin
            historyReg <= '0;
            for (int idx = 0; idx < tableDepth; idx++) begin
                counterTable[idx] <= counterInit;      // all weakly taken
            end
        end else if (branchValidNext) begin
            if (branchTakenNext) begin
                if (currentCounter != counterMax) begin
                    counterTable[historyReg] <= currentCounter + 1'b1;
                end
            end else begin
                if (currentCounter != counterMin) begin
                    counterTable[historyReg] <= currentCounter - 1'b1;
                end
            end
            historyReg <= {historyReg[historyBits-2:0], branchTakenNext}; // newest outcome in lsb
        end
    end

endmodule

/* source/branchResolver.sv */
module branchResolver (
    input  logic               clockSignal,
    input  logic               resetSignal,
    input  logic               resultValidNext,
    input  logic               overflowNext,
    input  logic               branchValidNext,
    input  logic               branchTakenNext,
    input  logic               predictedTaken,
    input  cpuDefsPkg::dataWord aluResult,
    input  cpuDefsPkg::dataWord branchTarget,
    input  cpuDefsPkg::dataWord pcPlus4,
    output logic               resultValid,
    output logic               overflowFlag,
    output logic               branchResolved,
    output logic               branchTaken,
    output logic               predictedTakenOut,
    output logic               mispredict,
    output cpuDefsPkg::dataWord resultData,
    output cpuDefsPkg::dataWord redirectPc
);
    import cpuDefsPkg::*;

    logic wrongGuess;
    dataWord nextPc;

    assign wrongGuess = branchTakenNext != predictedTaken;
    assign nextPc = branchTakenNext ? branchTarget : pcPlus4;   // fall through when not taken

    // status flags
    always_ff @(posedge clockSignal) begin
        if (resetSignal) begin
            resultValid <= 1'b0;
            overflowFlag <= 1'b0;
            branchResolved <= 1'b0;
            branchTaken <= 1'b0;
            predictedTakenOut <= 1'b0;
            mispredict <= 1'b0;
        end else begin
            resultValid <= resultValidNext;
            overflowFlag <= overflowNext;
            branchResolved <= branchValidNext;
            branchTaken <= branchValidNext && branchTakenNext;
            predictedTakenOut <= branchValidNext && predictedTaken;
            mispredict <= branchValidNext && wrongGuess;
        end
    end

    // payload, only loaded alongside its valid
    always_ff @(posedge clockSignal) begin
        if (resultValidNext) begin
            resultData <= aluResult;
        end
        if (branchValidNext) begin
            redirectPc <= nextPc;
        end
    end

endmodule

/* source/executeBranchTop.sv */
module executeBranchTop (
    input  logic               clockSignal,
    input  logic               resetSignal,
    input  logic               instrValid,
    input  cpuDefsPkg::dataWord instruction,
    input  cpuDefsPkg::dataWord operandA,
    input  cpuDefsPkg::dataWord operandB,
    input  cpuDefsPkg::dataWord pcPlus4,
    output logic               resultValid,
    output cpuDefsPkg::dataWord resultData,
    output logic               overflowFlag,
    output logic               branchResolved,
    output logic               branchTaken,
    output logic               predictedTakenOut,
    output logic               mispredict,
    output cpuDefsPkg::dataWord redirectPc
);
    import cpuDefsPkg::*;

    logic resultValidNext;
    logic overflowNext;
    logic branchValidNext;
    logic branchTakenNext;
    logic predictedTaken;
    dataWord aluResult;
    dataWord branchTarget;

    instructionExecute u_execute (
        .instrValid      (instrValid),
        .instruction     (instruction),
        .operandA        (operandA),
        .operandB        (operandB),
        .pcPlus4         (pcPlus4),
        .resultValidNext (resultValidNext),
        .overflowNext    (overflowNext),
        .branchValidNext (branchValidNext),
        .branchTakenNext (branchTakenNext),
        .aluResult       (aluResult),
        .branchTarget    (branchTarget)
    );

    // runs beside execute, trains on resolved beq
    globalHistoryPredictor u_predictor (
        .clockSignal     (clockSignal),
        .resetSignal     (resetSignal),
        .branchValidNext (branchValidNext),
        .branchTakenNext (branchTakenNext),
        .predictedTaken  (predictedTaken)
    );

    branchResolver u_resolver (
        .clockSignal       (clockSignal),
        .resetSignal       (resetSignal),
        .resultValidNext   (resultValidNext),
        .overflowNext      (overflowNext),
        .branchValidNext   (branchValidNext),
        .branchTakenNext   (branchTakenNext),
        .predictedTaken    (predictedTaken),
        .aluResult         (aluResult),
        .branchTarget      (branchTarget),
        .pcPlus4           (pcPlus4),
        .resultValid       (resultValid),
        .overflowFlag      (overflowFlag),
        .branchResolved    (branchResolved),
        .branchTaken       (branchTaken),
        .predictedTakenOut (predictedTakenOut),
        .mispredict        (mispredict),
        .resultData        (resultData),
        .redirectPc        (redirectPc)
    );

endmodule

/* sim/executeBranch_sva.sv */
module executeBranchSva (
    input logic clockSignal,
    input logic resetSignal,
    input logic resultValid,
    input logic branchResolved,
    input logic mispredict
);
    timeunit 1ns;
    timeprecision 1ps;

    int assertFailures = 0;

    mispredictOnBranch: assert property (@(posedge clockSignal) disable iff (resetSignal)
        mispredict |-> branchResolved)
        else begin
            assertFailures++;
            $error("mispredict raised without a resolved branch");
        end

    // a cycle carries either an alu result or a branch
    validsExclusive: assert property (@(posedge clockSignal) disable iff (resetSignal)
        !(resultValid && branchResolved))
        else begin
            assertFailures++;
            $error("resultValid and branchResolved high in the same cycle");
        end

    validsLowAfterReset: assert property (@(posedge clockSignal)
        resetSignal |=> (!resultValid && !branchResolved))
        else begin
            assertFailures++;
            $error("valid output high in the cycle after reset");
        end

endmodule

bind executeBranchTop executeBranchSva u_sva (
    .clockSignal    (clockSignal),
    .resetSignal    (resetSignal),
    .resultValid    (resultValid),
    .branchResolved (branchResolved),
    .mispredict     (mispredict)
);

/* sim/executeBranchTb.sv */
module executeBranchTb;
    timeunit 1ns;
    timeprecision 1ps;

    import cpuDefsPkg::*;

    typedef struct packed {
        logic resultValid;
        dataWord resultData;
        logic overflowFlag;
        logic branchResolved;
        logic branchTaken;
        logic predictedTaken;
        logic mispredict;
        dataWord redirectPc;
        int testId;
        int issueCycle;
    } expectType;

    localparam int resetCycles = 10;
    localparam int idleAfterReset = 3;
    localparam int randomAluCount = 60;
    localparam int unsupportedCount = 12;
    localparam int backToBackCount = 12;
    localparam int notTakenCount = 8;
    localparam int alternateCount = 12;
    localparam int mixedCount = 60;
    localparam int totalIssued = idleAfterReset + randomAluCount + unsupportedCount +
                                 backToBackCount + notTakenCount + alternateCount + mixedCount;
    localparam int cycleLimit = totalIssued + 200;

    logic clockSignal;
    logic resetSignal;
    logic instrValid;
    dataWord instruction;
    dataWord operandA;
    dataWord operandB;
    dataWord pcPlus4;
    logic resultValid;
    dataWord resultData;
    logic overflowFlag;
    logic branchResolved;
    logic branchTaken;
    logic predictedTakenOut;
    logic mispredict;
    dataWord redirectPc;

    historyType modelHistory;
    counterType modelCounters [tableDepth];
    expectType expectQueue [$];
    expectType headRecord;
    integer seed;
    int cycleCount = 0;
    int currentTest = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testErrors [6] = '{default: 0};
    int testChecks [6] = '{default: 0};
    string testNames [6] = '{"reset", "randomAlu", "unsupported", "backToBackBeq",
                             "training", "mixedStream"};
    logic [5:0] badOpcodes [6] = '{6'd1, 6'd2, 6'd3, 6'd5, 6'd12, 6'd63};
    logic [5:0] badFuncts [6] = '{6'd0, 6'd8, 6'd33, 6'd35, 6'd36, 6'd43};

    executeBranchTop u_dut (
        .clockSignal       (clockSignal),
        .resetSignal       (resetSignal),
        .instrValid        (instrValid),
        .instruction       (instruction),
        .operandA          (operandA),
        .operandB          (operandB),
        .pcPlus4           (pcPlus4),
        .resultValid       (resultValid),
        .resultData        (resultData),
        .overflowFlag      (overflowFlag),
        .branchResolved    (branchResolved),
        .branchTaken       (branchTaken),
        .predictedTakenOut (predictedTakenOut),
        .mispredict        (mispredict),
        .redirectPc        (redirectPc)
    );

    initial clockSignal = 1'b0;
    always #10 clockSignal = ~clockSignal;           // 20 ns period

    always @(posedge clockSignal) begin
        cycleCount <= cycleCount + 1;
    end

    // expected outputs for one issued cycle, prediction from the given counter
    function automatic expectType referenceResult(input logic valid, input dataWord instr,
            input dataWord a, input dataWord b, input dataWord pc, input counterType counter);
        expectType rec;
        logic [5:0] opcode;
        logic [5:0] funct;
        dataWord immValue;
        dataWord second;
        longint wideSum;
        logic isAdd;
        logic isSlt;
        rec = '0;
        opcode = instr[31:26];
        funct = instr[5:0];
        immValue = {{16{instr[15]}}, instr[15:0]};
        second = b;
        isAdd = 1'b0;
        isSlt = 1'b0;
        if (valid) begin
            case (opcode)
                6'd0: begin                                  // r-type, by funct
                    rec.resultValid = (funct == 6'd32) || (funct == 6'd34) || (funct == 6'd42);
                    if (funct == 6'd32) begin
                        isAdd = 1'b1;
                    end else if (funct == 6'd34) begin
                        rec.resultData = a - b;
                    end else if (funct == 6'd42) begin
                        isSlt = 1'b1;
                    end
                end
                6'd10: begin                                 // slti
                    rec.resultValid = 1'b1;
                    second = immValue;
                    isSlt = 1'b1;
                end
                6'd35, 6'd43: begin                          // lw and sw address
                    rec.resultValid = 1'b1;
                    second = immValue;
                    isAdd = 1'b1;
                end
                6'd4: begin
                    rec.branchResolved = 1'b1;
                    rec.branchTaken = (a == b);
                    rec.predictedTaken = (counter >= 2);
                    rec.mispredict = rec.branchTaken != rec.predictedTaken;
                    rec.redirectPc = rec.branchTaken ? pc + (immValue << 2) : pc;
                end
                default: rec.resultValid = 1'b0;
            endcase
        end
        if (isAdd) begin
            wideSum = longint'($signed(a)) + longint'($signed(second));
            rec.resultData = wideSum[31:0];
            rec.overflowFlag = wideSum != longint'($signed(wideSum[31:0])); // out of 32-bit range
        end
        if (isSlt) begin
            rec.resultData = ($signed(a) < $signed(second)) ? 32'd1 : 32'd0;
        end
        return rec;
    endfunction

    function automatic void trainModel(input logic taken);
        counterType counter;
        counter = modelCounters[modelHistory];
        if (taken && counter != 2'd3) begin
            counter = counter + 2'd1;
        end else if (!taken && counter != 2'd0) begin
            counter = counter - 2'd1;
        end
        modelCounters[modelHistory] = counter;
        modelHistory = {modelHistory[historyBits-2:0], taken};
    endfunction

    function automatic dataWord randomWord();
        return $random(seed);
    endfunction

    function automatic dataWord randomOperand();
        int unsigned pick;
        pick = $unsigned($random(seed)) % 3;
        if (pick == 0) begin
            return 32'h7fff_ff00 + ($unsigned($random(seed)) % 256);   // near max positive
        end else if (pick == 1) begin
            return 32'h8000_0000 + ($unsigned($random(seed)) % 256);   // near min negative
        end
        return randomWord();
    endfunction

    function automatic dataWord randomPc();
        dataWord pc;
        pc = randomWord();
        pc[1:0] = 2'b00;
        return pc;
    endfunction

    function automatic dataWord encodeRType(input logic [5:0] funct);
        dataWord word;
        word = randomWord();                             // random register fields
        word[31:26] = 6'd0;
        word[10:6] = 5'd0;
        word[5:0] = funct;
        return word;
    endfunction

    function automatic dataWord encodeIType(input logic [5:0] opcode);
        dataWord word;
        word = randomWord();                             // random rs, rt and immediate
        word[31:26] = opcode;
        return word;
    endfunction

    function automatic dataWord randomAluInstr();
        case ($unsigned($random(seed)) % 6)
            0: return encodeRType(6'd32);
            1: return encodeRType(6'd34);
            2: return encodeRType(6'd42);
            3: return encodeIType(6'd10);
            4: return encodeIType(6'd35);
            default: return encodeIType(6'd43);
        endcase
    endfunction

    task automatic checkValue(input int testId, input string fieldName, input dataWord expected,
            input dataWord actual);
        checkCount++;
        testChecks[testId]++;
        if (actual !== expected) begin
            errorCount++;
            testErrors[testId]++;
            $display("FAILED %s %s: expected %h, actual %h", testNames[testId], fieldName,
                     expected, actual);
        end
    endtask

    // called 2 ns after a rising edge, holds the inputs for one cycle
    task automatic issueInstruction(input logic valid, input dataWord instr, input dataWord a,
            input dataWord b, input dataWord pc);
        expectType rec;
        rec = referenceResult(valid, instr, a, b, pc, modelCounters[modelHistory]);
        rec.testId = currentTest;
        rec.issueCycle = cycleCount;
        expectQueue.push_back(rec);
        if (rec.branchResolved) begin
            trainModel(rec.branchTaken);
        end
        instrValid = valid;
        instruction = instr;
        operandA = a;
        operandB = b;
        pcPlus4 = pc;
        @(posedge clockSignal);
        #2;
    endtask

    task automatic finishTest();
        instrValid = 1'b0;
        while (expectQueue.size() != 0) begin
            @(negedge clockSignal);
        end
        @(posedge clockSignal);
        #2;
        $display("test %s finished: %0d checks, %0d errors", testNames[currentTest],
                 testChecks[currentTest], testErrors[currentTest]);
        currentTest++;
    endtask

    // compare at the falling edge, one cycle after issue
    always @(negedge clockSignal) begin
        if (expectQueue.size() != 0 && expectQueue[0].issueCycle < cycleCount) begin
            headRecord = expectQueue.pop_front();
            checkValue(headRecord.testId, "resultValid", headRecord.resultValid, resultValid);
            checkValue(headRecord.testId, "overflowFlag", headRecord.overflowFlag, overflowFlag);
            checkValue(headRecord.testId, "branchResolved", headRecord.branchResolved,
                       branchResolved);
            checkValue(headRecord.testId, "branchTaken", headRecord.branchTaken, branchTaken);
            checkValue(headRecord.testId, "predictedTakenOut", headRecord.predictedTaken,
                       predictedTakenOut);
            checkValue(headRecord.testId, "mispredict", headRecord.mispredict, mispredict);
            if (headRecord.resultValid) begin
                checkValue(headRecord.testId, "resultData", headRecord.resultData, resultData);
            end
            if (headRecord.branchResolved) begin
                checkValue(headRecord.testId, "redirectPc", headRecord.redirectPc, redirectPc);
            end
        end
    end

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clockSignal);
        end
        $display("timeout: tests still running after %0d clock cycles", cycleLimit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        dataWord a;
        dataWord b;
        dataWord instr;
        seed = 32'h880b459a;
        resetSignal = 1'b1;
        instrValid = 1'b0;
        instruction = '0;
        operandA = '0;
        operandB = '0;
        pcPlus4 = '0;
        modelHistory = '0;
        for (int idx = 0; idx < tableDepth; idx++) begin
            modelCounters[idx] = 2'd2;                   // weakly taken
        end
        repeat (resetCycles) @(posedge clockSignal);
        #2;
        checkValue(0, "resultValid", 1'b0, resultValid);
        checkValue(0, "branchResolved", 1'b0, branchResolved);
        checkValue(0, "mispredict", 1'b0, mispredict);
        resetSignal = 1'b0;
        repeat (idleAfterReset) begin
            issueInstruction(1'b0, randomWord(), randomWord(), randomWord(), randomPc());
        end
        finishTest();

        repeat (randomAluCount) begin
            instr = randomAluInstr();
            a = randomOperand();
            b = randomOperand();
            issueInstruction(1'b1, instr, a, b, randomPc());
        end
        finishTest();

        for (int idx = 0; idx < unsupportedCount; idx++) begin
            if (idx % 2 == 0) begin
                instr = encodeIType(badOpcodes[(idx / 2) % 6]);
            end else begin
                instr = encodeRType(badFuncts[(idx / 2) % 6]);
            end
            a = randomOperand();
            issueInstruction(1'b1, instr, a, a, randomPc());
        end
        finishTest();

        repeat (backToBackCount) begin
            a = randomWord();
            issueInstruction(1'b1, encodeIType(6'd4), a, a, randomPc());
        end
        finishTest();

        repeat (notTakenCount) begin
            a = randomWord();
            issueInstruction(1'b1, encodeIType(6'd4), a, ~a, randomPc());
        end
        for (int idx = 0; idx < alternateCount; idx++) begin
            a = randomWord();
            b = (idx % 2 == 0) ? a : a + 32'd1;          // taken, then not taken
            issueInstruction(1'b1, encodeIType(6'd4), a, b, randomPc());
        end
        finishTest();

        repeat (mixedCount) begin
            if ($unsigned($random(seed)) % 4 == 0) begin
                issueInstruction(1'b0, randomWord(), randomWord(), randomWord(), randomPc());
            end
            a = randomOperand();
            if ($unsigned($random(seed)) % 2 == 0) begin
                b = ($unsigned($random(seed)) % 2 == 0) ? a : randomOperand();
                instr = encodeIType(6'd4);
            end else begin
                b = randomOperand();
                instr = randomAluInstr();
            end
            issueInstruction(1'b1, instr, a, b, randomPc());
        end
        finishTest();

        errorCount = errorCount + u_dut.u_sva.assertFailures;
        $display("tests %0d, checks %0d, assertion failures %0d, errors %0d", currentTest,
                 checkCount, u_dut.u_sva.assertFailures, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/cpuDefsPkg.sv
execute/instructionExecute.sv
predictor/globalHistoryPredictor.sv
source/branchResolver.sv
source/executeBranchTop.sv
sim/executeBranch_sva.sv
sim/executeBranchTb.sv

/* Bender.yml */
package:
  name: execute_branch

sources:
  - common/cpuDefsPkg.sv
  - execute/instructionExecute.sv
  - predictor/globalHistoryPredictor.sv
  - source/branchResolver.sv
  - source/executeBranchTop.sv
  - target: simulation
    files:
      - sim/executeBranch_sva.sv
      - sim/executeBranchTb.sv
